// ==== compile.f ====
source/icache_geom_pkg.sv
source/wb_bus_pkg.sv
source/icache_tag_store.sv
source/icache_data_ram.sv
source/icache_word_counter.sv
source/icache_fill_fsm.sv
source/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

// ==== Makefile ====
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb;

  import icache_geom_pkg::*;
  import wb_bus_pkg::*;

  localparam int FETCHES = 400;
  localparam int CYCLE_LIMIT = FETCHES * 80;
  localparam int NUM_BASES = 12;
  localparam int LW_LOG2 = DEF_LINE_WORDS_LOG2;
  localparam int TAG_W = XLEN - LW_LOG2 - WORD_OFS_W;
  localparam logic [TAG_W-1:0] BASE_TAG = 'h400;
  // both have bit 2 of the tag set
  localparam logic [TAG_W-1:0] ERR_TAG_A = 'h404;
  localparam logic [TAG_W-1:0] ERR_TAG_B = 'h405;

  logic                clk_i;
  logic                reset_i;
  logic                fetch_req_i;
  logic [XLEN-1:0]     fetch_addr_i;
  logic                flush_i;
  logic                busy_o;
  logic                instr_valid_o;
  logic [ILEN-1:0]     instr_o;
  logic                fetch_err_o;
  logic                bus_req_o;
  logic                bus_gnt_i;
  logic                wb_cyc_o;
  logic                wb_stb_o;
  logic [WB_ADR_W-1:0] wb_adr_o;
  logic [WB_DAT_W-1:0] wb_dat_i;
  logic                wb_ack_i;
  logic                wb_err_i;
  int                  errors;
  int                  responses;
  int                  accepts;
  int                  total_errors;
  int                  cycles;
  int                  gnt_wait;
  int                  ack_wait;

  icache_top dut0 (.*);

  icache_checker checker0 (
    .errors_o    (errors),
    .responses_o (responses),
    .accepts_o   (accepts),
    .*
  );

  function automatic logic [31:0] memory_word(logic [WB_ADR_W-1:0] a);
    return (32'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;
  endfunction

  function automatic bit error_line(logic [WB_ADR_W-1:0] a);
    return (a[WB_ADR_W-1:LW_LOG2] == ERR_TAG_A) || (a[WB_ADR_W-1:LW_LOG2] == ERR_TAG_B);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // arbiter and memory slave
  always @(negedge clk_i) begin
    if (reset_i || !bus_req_o) begin
      bus_gnt_i <= 1'b0;
      wb_ack_i <= 1'b0;
      wb_err_i <= 1'b0;
      gnt_wait <= $urandom % 4;
      ack_wait <= $urandom % 4;
    end else if (!bus_gnt_i) begin
      if (gnt_wait == 0) begin
        bus_gnt_i <= 1'b1;
      end else begin
        gnt_wait <= gnt_wait - 1;
      end
    end else if (wb_cyc_o) begin
      if (ack_wait == 0) begin
        if (error_line(wb_adr_o)) begin
          wb_ack_i <= 1'b0;
          wb_err_i <= 1'b1;
        end else begin
          wb_ack_i <= 1'b1;
          wb_dat_i <= memory_word(wb_adr_o);
        end
        ack_wait <= $urandom % 4;
      end else begin
        wb_ack_i <= 1'b0;
        wb_err_i <= 1'b0;
        ack_wait <= ack_wait - 1;
      end
    end
  end

  task automatic issue_fetch();
    logic [TAG_W-1:0]   tag;
    logic [LW_LOG2-1:0] word;
    tag = BASE_TAG + TAG_W'($urandom % NUM_BASES);
    word = LW_LOG2'($urandom);
    while (busy_o) @(negedge clk_i);
    fetch_req_i = 1'b1;
    fetch_addr_i = {tag, word, WORD_OFS_W'($urandom)};
    @(negedge clk_i);
    fetch_req_i = 1'b0;
  endtask

  task automatic issue_flush();
    while (busy_o) @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  // run limit
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout");
        $display(">>> FAIL");
        $finish;
      end
    end
  end

  initial begin
    void'($urandom(32'h7946ed65));
    reset_i = 1'b1;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    flush_i = 1'b0;
    bus_gnt_i = 1'b0;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    for (int i = 0; i < FETCHES; i++) begin
      if ($urandom % 50 == 0) begin
        issue_flush();
      end
      issue_fetch();
      repeat ($urandom % 3) @(negedge clk_i);
    end
    while (busy_o) @(negedge clk_i);
    repeat (3) @(negedge clk_i);

    total_errors = errors;
    if (responses != accepts) begin
      $display("error: %0d fetches accepted but %0d answered", accepts, responses);
      total_errors++;
    end
    $display("errors: %0d from checker, %0d total; %0d fetches, %0d responses",
             errors, total_errors, accepts, responses);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/icache_checker.sv ====
`timescale 1ns/100ps

module icache_checker #(
  parameter int LINES_LOG2      = icache_geom_pkg::DEF_LINES_LOG2,
  parameter int LINE_WORDS_LOG2 = icache_geom_pkg::DEF_LINE_WORDS_LOG2
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             fetch_req_i,
  input  logic [icache_geom_pkg::XLEN-1:0] fetch_addr_i,
  input  logic                             flush_i,
  input  logic                             busy_o,
  input  logic                             instr_valid_o,
  input  logic [icache_geom_pkg::ILEN-1:0] instr_o,
  input  logic                             fetch_err_o,
  input  logic                             bus_req_o,
  input  logic                             bus_gnt_i,
  input  logic                             wb_cyc_o,
  input  logic                             wb_stb_o,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0]  wb_adr_o,
  input  logic                             wb_ack_i,
  input  logic                             wb_err_i,
  output int                               errors_o,
  output int                               responses_o,
  output int                               accepts_o
);

  import icache_geom_pkg::*;

  localparam int LINES = 2 ** LINES_LOG2;
  localparam int WORDS = 2 ** LINE_WORDS_LOG2;
  localparam int TAG_W = XLEN - LINE_WORDS_LOG2 - WORD_OFS_W;

  // reference cache state
  logic [TAG_W-1:0] m_tag [LINES];
  logic [LINES-1:0] m_valid;
  int               m_victim;
  logic             hit_pending;
  logic [ILEN-1:0]  hit_data;
  logic             err_pending;
  logic             in_fill;
  logic             granted;
  logic [XLEN-1:0]  fill_addr;
  int               beat;
  int               done_cnt;

  function automatic logic [31:0] memory_word(logic [29:0] a);
    return (32'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;
  endfunction

  function automatic bit model_hit(logic [TAG_W-1:0] tag);
    for (int i = 0; i < LINES; i++) begin
      if (m_valid[i] && m_tag[i] == tag) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors_o++;
      $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(string msg);
    errors_o++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // all values are those before the edge
  always @(posedge clk_i) begin : sample
    logic exp_valid;
    logic exp_req;
    logic exp_cyc;
    logic [29:0] exp_adr;
    if (reset_i) begin
      m_valid = '0;
      m_victim = 0;
      hit_pending = 1'b0;
      err_pending = 1'b0;
      in_fill = 1'b0;
      granted = 1'b0;
      done_cnt = 0;
      errors_o = 0;
      responses_o = 0;
      accepts_o = 0;
    end else begin
      // replay result lands three cycles after the last ack
      exp_valid = hit_pending || (done_cnt == 1);
      check_value("instr_valid_o", 32'(instr_valid_o), 32'(exp_valid));
      if (exp_valid) begin
        check_value("instr_o", instr_o,
                    hit_pending ? hit_data : memory_word(fill_addr[XLEN-1:2]));
      end
      check_value("fetch_err_o", 32'(fetch_err_o), 32'(err_pending));
      check_value("busy_o", 32'(busy_o), 32'(in_fill && done_cnt != 1));
      // bus held from the miss until the last ack, cycle only after grant
      exp_req = in_fill && (done_cnt == 0);
      exp_cyc = exp_req && granted;
      check_value("bus_req_o", 32'(bus_req_o), 32'(exp_req));
      check_value("wb_cyc_o", 32'(wb_cyc_o), 32'(exp_cyc));
      check_value("wb_stb_o", 32'(wb_stb_o), 32'(exp_cyc));
      if (instr_valid_o || fetch_err_o) begin
        responses_o++;
      end
      if (done_cnt == 1) begin
        in_fill = 1'b0;
      end
      if (done_cnt > 0) begin
        done_cnt--;
      end
      hit_pending = 1'b0;
      err_pending = 1'b0;

      // grant seen while the fill waits in arbitration
      if (in_fill && bus_gnt_i) begin
        granted = 1'b1;
      end

      // one bus transfer finished
      if (wb_cyc_o && (wb_ack_i || wb_err_i)) begin
        if (!in_fill) begin
          report_error("bus transfer outside a line fill");
        end
        exp_adr = {fill_addr[XLEN-1 -: TAG_W], LINE_WORDS_LOG2'(beat)};
        check_value("wb_adr_o", 32'(wb_adr_o), 32'(exp_adr));
        if (wb_err_i) begin
          in_fill = 1'b0;
          err_pending = 1'b1;
        end else begin
          beat++;
          if (beat == WORDS) begin
            m_tag[m_victim] = fill_addr[XLEN-1 -: TAG_W];
            m_valid[m_victim] = 1'b1;
            m_victim = (m_victim + 1) % LINES;
            done_cnt = 3;
          end
        end
      end

      if (fetch_req_i && !busy_o && !flush_i) begin
        accepts_o++;
        if (model_hit(fetch_addr_i[XLEN-1 -: TAG_W])) begin
          hit_pending = 1'b1;
          hit_data = memory_word(fetch_addr_i[XLEN-1:2]);
        end else begin
          in_fill = 1'b1;
          granted = 1'b0;
          fill_addr = fetch_addr_i;
          beat = 0;
        end
      end

      if (flush_i && !busy_o) begin
        m_valid = '0;
        m_victim = 0;
      end
    end
  end

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/100ps

module icache_top #(
  parameter int LINES_LOG2      = icache_geom_pkg::DEF_LINES_LOG2,
  parameter int LINE_WORDS_LOG2 = icache_geom_pkg::DEF_LINE_WORDS_LOG2
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             fetch_req_i,
  input  logic [icache_geom_pkg::XLEN-1:0] fetch_addr_i,
  input  logic                             flush_i,
  output logic                             busy_o,
  output logic                             instr_valid_o,
  output logic [icache_geom_pkg::ILEN-1:0] instr_o,
  output logic                             fetch_err_o,
  output logic                             bus_req_o,
  input  logic                             bus_gnt_i,
  output logic                             wb_cyc_o,
  output logic                             wb_stb_o,
  output logic [wb_bus_pkg::WB_ADR_W-1:0]  wb_adr_o,
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]  wb_dat_i,
  input  logic                             wb_ack_i,
  input  logic                             wb_err_i
);

  import icache_geom_pkg::*;

  localparam int RAM_AW = LINES_LOG2 + LINE_WORDS_LOG2;

  logic [XLEN-1:0]            lookup_addr;
  logic [XLEN-1:0]            commit_addr;
  logic                       commit;
  logic                       hit;
  logic [LINES_LOG2-1:0]      hit_line;
  logic [LINES_LOG2-1:0]      fill_line;
  logic                       count_clear;
  logic                       count_step;
  logic [LINE_WORDS_LOG2-1:0] word_idx;
  logic                       last_word;
  logic [RAM_AW-1:0]          ram_rd_addr;
  logic [RAM_AW-1:0]          ram_wr_addr;
  logic                       ram_wr_en;

  icache_tag_store #(
    .LINES_LOG2      (LINES_LOG2),
    .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
  ) tags0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_addr_i (lookup_addr),
    .commit_i      (commit),
    .commit_addr_i (commit_addr),
    // a flush only counts between fills
    .flush_i       (flush_i && !busy_o),
    .hit_o         (hit),
    .hit_line_o    (hit_line),
    .fill_line_o   (fill_line)
  );

  icache_data_ram #(
    .LINES_LOG2      (LINES_LOG2),
    .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
  ) ram0 (
    .clk_i     (clk_i),
    .wr_en_i   (ram_wr_en),
    .wr_addr_i (ram_wr_addr),
    .wr_data_i (wb_dat_i),
    .rd_addr_i (ram_rd_addr),
    .rd_data_o (instr_o)
  );

  icache_word_counter #(
    .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
  ) count0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .clear_i (count_clear),
    .step_i  (count_step),
    .index_o (word_idx),
    .last_o  (last_word)
  );

  icache_fill_fsm #(
    .LINES_LOG2      (LINES_LOG2),
    .LINE_WORDS_LOG2 (LINE_WORDS_LOG2)
  ) fsm0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .flush_i       (flush_i),
    .busy_o        (busy_o),
    .instr_valid_o (instr_valid_o),
    .fetch_err_o   (fetch_err_o),
    .lookup_addr_o (lookup_addr),
    .commit_o      (commit),
    .commit_addr_o (commit_addr),
    .hit_i         (hit),
    .hit_line_i    (hit_line),
    .fill_line_i   (fill_line),
    .count_clear_o (count_clear),
    .count_step_o  (count_step),
    .word_idx_i    (word_idx),
    .last_word_i   (last_word),
    .ram_rd_addr_o (ram_rd_addr),
    .ram_wr_en_o   (ram_wr_en),
    .ram_wr_addr_o (ram_wr_addr),
    .bus_gnt_i     (bus_gnt_i),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .bus_req_o     (bus_req_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o)
  );

endmodule

// ==== source/icache_fill_fsm.sv ====
`timescale 1ns/100ps

module icache_fill_fsm #(
  parameter int LINES_LOG2      = icache_geom_pkg::DEF_LINES_LOG2,
  parameter int LINE_WORDS_LOG2 = icache_geom_pkg::DEF_LINE_WORDS_LOG2
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  fetch_req_i,
  input  logic [icache_geom_pkg::XLEN-1:0]      fetch_addr_i,
  input  logic                                  flush_i,
  output logic                                  busy_o,
  output logic                                  instr_valid_o,
  output logic                                  fetch_err_o,
  output logic [icache_geom_pkg::XLEN-1:0]      lookup_addr_o,
  output logic                                  commit_o,
  output logic [icache_geom_pkg::XLEN-1:0]      commit_addr_o,
  input  logic                                  hit_i,
  input  logic [LINES_LOG2-1:0]                 hit_line_i,
  input  logic [LINES_LOG2-1:0]                 fill_line_i,
  output logic                                  count_clear_o,
  output logic                                  count_step_o,
  input  logic [LINE_WORDS_LOG2-1:0]            word_idx_i,
  input  logic                                  last_word_i,
  output logic [LINES_LOG2+LINE_WORDS_LOG2-1:0] ram_rd_addr_o,
  output logic                                  ram_wr_en_o,
  output logic [LINES_LOG2+LINE_WORDS_LOG2-1:0] ram_wr_addr_o,
  input  logic                                  bus_gnt_i,
  input  logic                                  wb_ack_i,
  input  logic                                  wb_err_i,
  output logic                                  bus_req_o,
  output logic                                  wb_cyc_o,
  output logic                                  wb_stb_o,
  output logic [wb_bus_pkg::WB_ADR_W-1:0]       wb_adr_o
);

  import icache_geom_pkg::*;

  localparam int TAG_W = XLEN - LINE_WORDS_LOG2 - WORD_OFS_W;

  typedef enum logic [2:0] {
    IDLE,
    ARB,
    READ,
    COMMIT,
    REPLAY,
    ERROR
  } state_t;

  state_t                     state_q;
  state_t                     state_d;
  logic [XLEN-1:0]            work_addr;
  logic [TAG_W-1:0]           work_tag;
  logic [LINE_WORDS_LOG2-1:0] lookup_word;
  logic                       ready;
  logic                       accept;
  logic                       miss;
  logic                       instr_valid_q;

  // ERROR lasts one cycle and takes requests like IDLE
  assign ready = (state_q == IDLE) || (state_q == ERROR);
  assign busy_o = !ready;
  assign accept = ready && fetch_req_i && !flush_i;
  assign miss = accept && !hit_i;

  // lookup follows the core until a miss, then holds the missed address
  assign lookup_addr_o = ready ? fetch_addr_i : work_addr;
  assign lookup_word = lookup_addr_o[LINE_WORDS_LOG2+WORD_OFS_W-1:WORD_OFS_W];
  assign ram_rd_addr_o = {hit_line_i, lookup_word};

  // burst address is line base plus acked word count
  assign work_tag = work_addr[XLEN-1 -: TAG_W];
  assign wb_adr_o = {work_tag, word_idx_i};

  assign bus_req_o = (state_q == ARB) || (state_q == READ);
  assign wb_cyc_o = (state_q == READ);
  assign wb_stb_o = (state_q == READ);

  // acked words land in the victim line
  assign ram_wr_en_o = wb_cyc_o && wb_ack_i;
  assign ram_wr_addr_o = {fill_line_i, word_idx_i};
  assign count_step_o = ram_wr_en_o;
  assign count_clear_o = miss || (state_q == ERROR);

  assign commit_o = (state_q == COMMIT);
  assign commit_addr_o = work_addr;
  assign fetch_err_o = (state_q == ERROR);
  assign instr_valid_o = instr_valid_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, ERROR: begin
        state_d = miss ? ARB : IDLE;
      end
      ARB: begin
        if (bus_gnt_i) begin
          state_d = READ;
        end
      end
      READ: begin
        if (wb_err_i) begin
          state_d = ERROR;
        end else if (wb_ack_i && last_word_i) begin
          state_d = COMMIT;
        end
      end
      // tag written at the end of COMMIT, so REPLAY looks it up like a hit
      COMMIT: state_d = REPLAY;
      REPLAY: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      instr_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // ram read data is valid one cycle after a hit or the replay
      instr_valid_q <= (accept && hit_i) || (state_q == REPLAY);
    end
  end

  // missed address held for the whole fill
  always_ff @(posedge clk_i) begin
    if (miss) begin
      work_addr <= fetch_addr_i;
    end
  end

endmodule

// ==== source/icache_word_counter.sv ====
`timescale 1ns/100ps

module icache_word_counter #(
  parameter int LINE_WORDS_LOG2 = icache_geom_pkg::DEF_LINE_WORDS_LOG2
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       clear_i,
  input  logic                       step_i,
  output logic [LINE_WORDS_LOG2-1:0] index_o,
  output logic                       last_o
);

  logic [LINE_WORDS_LOG2-1:0] count;

  // one step per acked word
  // wraps back to 0 after the final word of a complete line
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count <= '0;
    end else if (clear_i) begin
      count <= '0;
    end else if (step_i) begin
      count <= count + 1'b1;
    end
  end

  assign index_o = count;

  // final word of the line is on the bus
  assign last_o = &count;

endmodule

// ==== source/icache_data_ram.sv ====
`timescale 1ns/100ps

module icache_data_ram #(
  parameter int LINES_LOG2      = icache_geom_pkg::DEF_LINES_LOG2,
  parameter int LINE_WORDS_LOG2 = icache_geom_pkg::DEF_LINE_WORDS_LOG2
) (
  input  logic                                  clk_i,
  input  logic                                  wr_en_i,
  input  logic [LINES_LOG2+LINE_WORDS_LOG2-1:0] wr_addr_i,
  input  logic [icache_geom_pkg::ILEN-1:0]      wr_data_i,
  input  logic [LINES_LOG2+LINE_WORDS_LOG2-1:0] rd_addr_i,
  output logic [icache_geom_pkg::ILEN-1:0]      rd_data_o
);

  import icache_geom_pkg::*;

  // address is {line, word}
  localparam int ADDR_W = LINES_LOG2 + LINE_WORDS_LOG2;
  localparam int DEPTH = 2 ** ADDR_W;

  logic [ILEN-1:0] mem [DEPTH];

  // fill writes one word per ack
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, data arrives the cycle after the address
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// ==== source/icache_tag_store.sv ====
`timescale 1ns/100ps

module icache_tag_store #(
  parameter int LINES_LOG2      = icache_geom_pkg::DEF_LINES_LOG2,
  parameter int LINE_WORDS_LOG2 = icache_geom_pkg::DEF_LINE_WORDS_LOG2
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [icache_geom_pkg::XLEN-1:0] lookup_addr_i,
  input  logic                              commit_i,
  input  logic [icache_geom_pkg::XLEN-1:0] commit_addr_i,
  input  logic                              flush_i,
  output logic                              hit_o,
  output logic [LINES_LOG2-1:0]             hit_line_o,
  output logic [LINES_LOG2-1:0]             fill_line_o
);

  import icache_geom_pkg::*;

  localparam int LINES = 2 ** LINES_LOG2;
  localparam int TAG_W = XLEN - LINE_WORDS_LOG2 - WORD_OFS_W;

  logic [TAG_W-1:0]      tags [LINES];
  logic [LINES-1:0]      valid;
  logic [LINES_LOG2-1:0] victim;
  logic [TAG_W-1:0]      lookup_tag;
  logic [TAG_W-1:0]      commit_tag;

  // tag is everything above the word offset within the line
  assign lookup_tag = lookup_addr_i[XLEN-1 -: TAG_W];
  assign commit_tag = commit_addr_i[XLEN-1 -: TAG_W];

  // search all lines at once
  always_comb begin
    hit_o = 1'b0;
    hit_line_o = '0;
    for (int i = 0; i < LINES; i++) begin
      if (valid[i] && (tags[i] == lookup_tag)) begin
        hit_o = 1'b1;
        hit_line_o = LINES_LOG2'(i);
      end
    end
  end

  // next line to be replaced
  assign fill_line_o = victim;

  // valid bits and round-robin pointer
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid <= '0;
      victim <= '0;
    end else if (commit_i) begin
      valid[victim] <= 1'b1;
      victim <= victim + 1'b1;
    end
  end

  // tag values only matter once the valid bit is set
  always_ff @(posedge clk_i) begin
    if (commit_i) begin
      tags[victim] <= commit_tag;
    end
  end

endmodule

// ==== source/wb_bus_pkg.sv ====
package wb_bus_pkg;

  // word address, the byte offset is not carried on the bus
  localparam int WB_ADR_W = icache_geom_pkg::XLEN - icache_geom_pkg::WORD_OFS_W;

  // full words only
  localparam int WB_DAT_W = 32;

endpackage

// ==== source/icache_geom_pkg.sv ====
package icache_geom_pkg;

  // core address width in bits
  localparam int XLEN = 32;

  // instruction word width
  localparam int ILEN = 32;

  // default geometry is 8 lines of 16 words
  localparam int DEF_LINES_LOG2 = 3;
  localparam int DEF_LINE_WORDS_LOG2 = 4;

  // byte offset bits inside one instruction word
  localparam int WORD_OFS_W = 2;

endpackage
